// ==== dmem.f ====
+incdir+sim
rtl/mem_cfg_pkg.sv
rtl/mem_access_pkg.sv
rtl/ram_single_port.sv
rtl/dmem_store_align.sv
rtl/dmem_load_format.sv
rtl/dmem_top.sv
sim/dmem_tb.sv

// ==== rtl/dmem_load_format.sv ====
`timescale 1ns/100ps

module dmem_load_format
	import mem_cfg_pkg::*;
	import mem_access_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  meta_valid,
	input  load_meta_t            meta,
	input  logic [data_width-1:0] rdata,
	output logic                  resp_valid,
	output mem_resp_t             resp
);

	// one stage per ram read cycle.
	logic [ram_read_latency-1:0] valid_pipe;
	load_meta_t                  meta_pipe [ram_read_latency];

	logic                  out_valid;
	load_meta_t            out_meta;
	logic [data_width-1:0] shifted;
	logic [data_width-1:0] load_data;
	int unsigned           load_bits;
	logic                  sign_bit;

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_pipe <= '0;
		end else begin
			valid_pipe[0] <= meta_valid;
			for (int i = 1; i < ram_read_latency; i++) begin
				valid_pipe[i] <= valid_pipe[i-1];
			end
		end
	end

	always_ff @(posedge clk) begin
		meta_pipe[0] <= meta;
		for (int i = 1; i < ram_read_latency; i++) begin
			meta_pipe[i] <= meta_pipe[i-1];
		end
	end

	// lines up with rdata.
	assign out_valid = valid_pipe[ram_read_latency-1];
	assign out_meta = meta_pipe[ram_read_latency-1];

	// addressed lanes down to bit 0, then extend above the access size.
	always_comb begin
		shifted = rdata >> (out_meta.offset * byte_width);
		load_bits = byte_width << out_meta.size;
		sign_bit = out_meta.is_signed && shifted[load_bits-1];
		for (int i = 0; i < data_width; i++) begin
			load_data[i] = (i < load_bits) ? shifted[i] : sign_bit;
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			resp_valid <= 1'b0;
		else
			resp_valid <= out_valid;
	end

	always_ff @(posedge clk) begin
		resp.rdata <= (out_meta.write || out_meta.err) ? '0 : load_data;
		resp.err <= out_meta.err;
		resp.was_write <= out_meta.write;
		resp.tag <= out_meta.tag;
	end

	// err from the aligner matches the size and offset that reach this stage,
	// stores at a nonzero offset included.
	assert property (@(posedge clk) disable iff (reset)
		out_valid |-> out_meta.err == !is_aligned(out_meta.size, out_meta.offset))
		else $error("dmem_load_format: err flag disagrees with alignment");

endmodule

// ==== rtl/dmem_store_align.sv ====
`timescale 1ns/100ps

module dmem_store_align
	import mem_cfg_pkg::*;
	import mem_access_pkg::*;
(
	input  logic       req_valid,
	input  mem_req_t   req,
	output ram_cmd_t   cmd,
	output logic       meta_valid,
	output load_meta_t meta
);

	byte_offset_t offset;
	logic         aligned;
	strobe_t      size_lanes;
	int unsigned  size_bytes;

	assign offset = req.addr[offset_width-1:0];
	assign aligned = is_aligned(req.size, offset);
	assign size_bytes = 1 << req.size;

	// lanes covered by the access, before the offset shift.
	always_comb begin
		for (int i = 0; i < lanes_per_word; i++) begin
			size_lanes[i] = (i < size_bytes);
		end
	end

	// misaligned requests leave the ram idle.
	assign cmd.en = req_valid && aligned;
	assign cmd.word_addr = req.addr[byte_addr_width-1:offset_width];

	always_comb begin
		if (req_valid && aligned && req.write)
			cmd.strobe = size_lanes << offset;
		else
			cmd.strobe = '0; // loads read with no strobe.
	end

	// lane i takes byte (i mod size) of the value.
	always_comb begin
		for (int i = 0; i < lanes_per_word; i++) begin
			cmd.wdata[i*byte_width +: byte_width] =
				req.wdata[(i & (size_bytes - 1))*byte_width +: byte_width];
		end
	end

	assign meta_valid = req_valid;

	always_comb begin
		meta.size = req.size;
		meta.is_signed = req.is_signed;
		meta.offset = offset;
		meta.err = !aligned;
		meta.write = req.write;
		meta.tag = req.tag;
	end

endmodule

// ==== rtl/dmem_top.sv ====
`timescale 1ns/100ps

module dmem_top
	import mem_cfg_pkg::*;
	import mem_access_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      req_valid,
	input  mem_req_t  req,
	output logic      resp_valid,
	output mem_resp_t resp
);

	ram_cmd_t              cmd;
	logic                  meta_valid;
	load_meta_t            meta;
	logic [data_width-1:0] rdata;

	dmem_store_align store_align_i (
		.req_valid  (req_valid),
		.req        (req),
		.cmd        (cmd),
		.meta_valid (meta_valid),
		.meta       (meta)
	);

	ram_single_port #(
		.addr_width   (word_addr_width),
		.data_width   (data_width),
		.byte_width   (byte_width),
		.read_latency (ram_read_latency)
	) ram_i (
		.clk    (clk),
		.en     (cmd.en),
		.addr   (cmd.word_addr),
		.strobe (cmd.strobe),
		.wdata  (cmd.wdata),
		.rdata  (rdata)
	);

	dmem_load_format load_format_i (
		.clk        (clk),
		.reset      (reset),
		.meta_valid (meta_valid),
		.meta       (meta),
		.rdata      (rdata),
		.resp_valid (resp_valid),
		.resp       (resp)
	);

endmodule

// ==== rtl/mem_access_pkg.sv ====
package mem_access_pkg;
	import mem_cfg_pkg::*;

	typedef enum logic [1:0] {
		size_byte,
		size_half,
		size_word,
		size_double
	} access_size_t;

	typedef logic [byte_addr_width-1:0] byte_addr_t;
	typedef logic [word_addr_width-1:0] word_addr_t;
	typedef logic [offset_width-1:0]    byte_offset_t;
	typedef logic [data_width-1:0]      word_t;
	typedef logic [lanes_per_word-1:0]  strobe_t;
	typedef logic [tag_width-1:0]       tag_t;

	typedef struct packed {
		logic         write;
		access_size_t size;
		logic         is_signed;
		byte_addr_t   addr;
		word_t        wdata; // right-aligned.
		tag_t         tag;
	} mem_req_t;

	typedef struct packed {
		word_t rdata; // extended, zero for stores and errors.
		logic  err;
		logic  was_write;
		tag_t  tag;
	} mem_resp_t;

	typedef struct packed {
		access_size_t size;
		logic         is_signed;
		byte_offset_t offset;
		logic         err;
		logic         write;
		tag_t         tag;
	} load_meta_t;

	typedef struct packed {
		logic       en;
		word_addr_t word_addr;
		strobe_t    strobe;
		word_t      wdata; // replicated over all lanes.
	} ram_cmd_t;

	// aligned when the offset is a multiple of the access size in bytes.
	function automatic logic is_aligned(access_size_t size, byte_offset_t offset);
		byte_offset_t low_mask;
		low_mask = byte_offset_t'((1 << size) - 1);
		return (offset & low_mask) == '0;
	endfunction

endpackage

// ==== rtl/mem_cfg_pkg.sv ====
package mem_cfg_pkg;

	// word geometry.
	localparam int data_width = 64;
	localparam int byte_width = 8;
	localparam int lanes_per_word = data_width / byte_width;

	// byte offset inside a word.
	localparam int offset_width = $clog2(lanes_per_word);

	// 1024 words of 8 bytes.
	localparam int word_addr_width = 10;
	localparam int byte_addr_width = word_addr_width + offset_width;

	// ram read path, address edge to rdata.
	localparam int ram_read_latency = 2;

	// request edge to response edge; the extra cycle is the output register.
	localparam int resp_latency = ram_read_latency + 1;

	localparam int tag_width = 4;

endpackage

// ==== rtl/ram_single_port.sv ====
`timescale 1ns/100ps

module ram_single_port #(
	parameter int addr_width = 10,
	parameter int data_width = 64,
	parameter int byte_width = 8,
	parameter int read_latency = 1,
	localparam int num_lanes = data_width / byte_width,
	localparam int num_words = 2 ** addr_width
) (
	input  logic                  clk,
	input  logic                  en,
	input  logic [addr_width-1:0] addr,
	input  logic [num_lanes-1:0]  strobe,
	input  logic [data_width-1:0] wdata,
	output logic [data_width-1:0] rdata
);

	typedef logic [num_lanes-1:0][byte_width-1:0] lane_bundle_t;

	typedef union packed {
		logic [data_width-1:0] word;
		lane_bundle_t          lanes;
	} word_view_t;

	word_view_t mem [num_words] = '{default: '0}; // zero at start.
	word_view_t wdata_view;

	assign wdata_view = wdata;

	// byte lane writes.
	always_ff @(posedge clk) begin
		if (en) begin
			for (int i = 0; i < num_lanes; i++) begin
				if (strobe[i])
					mem[addr].lanes[i] <= wdata_view.lanes[i];
			end
		end
	end

	if (read_latency == 0) begin : gen_comb_read
		assign rdata = mem[addr].word;
	end else begin : gen_reg_read
		logic [data_width-1:0] read_pipe [read_latency];

		// read first: a write on the same edge is seen by the next read.
		always_ff @(posedge clk) begin
			if (en)
				read_pipe[0] <= mem[addr].word;
			for (int i = 1; i < read_latency; i++) begin
				read_pipe[i] <= read_pipe[i-1];
			end
		end

		assign rdata = read_pipe[read_latency-1];
	end

	// the caller keeps the strobe clear when the port is idle.
	assert property (@(posedge clk) !en |-> strobe == '0)
		else $error("ram_single_port: strobe set while en is low");

endmodule

// ==== sim/dmem_ref.svh ====
`ifndef DMEM_REF_SVH
`define DMEM_REF_SVH

// included inside dmem_tb, after its package imports.

// shadow memory, one entry per byte address.
logic [byte_width-1:0] shadow_mem [2 ** byte_addr_width] = '{default: '0};

function automatic void write_bytes(mem_req_t req);
	int n;
	n = 1 << req.size;
	for (int i = 0; i < n; i++) begin
		shadow_mem[req.addr + i] = req.wdata[i*byte_width +: byte_width];
	end
endfunction

function automatic logic [data_width-1:0] read_extended(mem_req_t req);
	int n;
	logic [data_width-1:0] value;
	n = 1 << req.size;
	value = '0;
	for (int i = 0; i < n; i++) begin
		value[i*byte_width +: byte_width] = shadow_mem[req.addr + i];
	end
	if (req.is_signed && value[n*byte_width-1]) begin
		for (int i = n * byte_width; i < data_width; i++) begin
			value[i] = 1'b1;
		end
	end
	return value;
endfunction

// applies the request at once and returns its expected response.
function automatic mem_resp_t expected_resp(mem_req_t req);
	mem_resp_t resp;
	resp = '0;
	resp.err = (req.addr % (1 << req.size)) != 0; // address a multiple of the size.
	resp.was_write = req.write;
	resp.tag = req.tag;
	if (!resp.err) begin
		if (req.write)
			write_bytes(req);
		else
			resp.rdata = read_extended(req);
	end
	return resp;
endfunction

`endif

// ==== sim/dmem_tb.sv ====
`timescale 1ns/100ps

module dmem_tb
	import mem_cfg_pkg::*;
	import mem_access_pkg::*;
;

	logic      clk;
	logic      reset;
	logic      req_valid;
	mem_req_t  req;
	logic      resp_valid;
	mem_resp_t resp;

	mem_resp_t exp_q [$]; // expected responses, oldest first.
	int        issue_q [$];
	int        edge_count = 0;
	int        errors = 0;
	int        checks = 0;
	tag_t      next_tag = '0;
	bit        timed_out;

	`include "dmem_ref.svh"

	dmem_top dut_i (
		.clk        (clk),
		.reset      (reset),
		.req_valid  (req_valid),
		.req        (req),
		.resp_valid (resp_valid),
		.resp       (resp)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) edge_count <= edge_count + 1;

	task automatic check(string what, logic [63:0] got, logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	// one request on the next falling edge; sampled on the rising edge after it.
	task automatic issue(logic write, access_size_t size, logic is_signed,
			byte_addr_t addr, word_t wdata);
		@(negedge clk);
		req_valid = 1'b1;
		req.write = write;
		req.size = size;
		req.is_signed = is_signed;
		req.addr = addr;
		req.wdata = wdata;
		req.tag = next_tag;
		next_tag++;
		exp_q.push_back(expected_resp(req));
		issue_q.push_back(edge_count + 1);
	endtask

	task automatic idle(int cycles);
		repeat (cycles) begin
			@(negedge clk);
			req_valid = 1'b0;
			req = '0;
		end
	endtask

	task automatic drain(output bit late);
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < 50) begin
			@(negedge clk);
			waited++;
		end
		late = (exp_q.size() != 0);
	endtask

	// outputs are read on the falling edge, half a cycle after they change.
	initial begin : compare
		mem_resp_t exp;
		int issued;
		forever begin
			@(negedge clk);
			if (!reset && resp_valid === 1'b1) begin
				if (exp_q.size() == 0) begin
					$display("error at %0t: response with no request outstanding", $time);
					errors++;
				end else begin
					exp = exp_q.pop_front();
					issued = issue_q.pop_front();
					check("rdata", resp.rdata, exp.rdata);
					check("err", resp.err, exp.err);
					check("was_write", resp.was_write, exp.was_write);
					check("tag", resp.tag, exp.tag);
					// counted to the rising edge that samples it.
					check("latency", edge_count + 1 - issued, resp_latency);
				end
			end
		end
	end

	initial begin
		access_size_t size;
		byte_addr_t   addr;
		void'($urandom(32'h0e7b_4251));
		reset = 1'b1;
		req_valid = 1'b0;
		req = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		idle(10); // nothing may come out.

		for (int s = 0; s < 4; s++) begin
			size = access_size_t'(s);
			addr = 13'h100 + s * 16 + ((s < 3) ? (1 << s) : 0);
			issue(1'b1, size, 1'b0, addr, 64'hf1e2_d3c4_b5a6_9788);
			issue(1'b0, size, 1'b1, addr, '0);
			issue(1'b0, size, 1'b0, addr, '0);
			issue(1'b1, size, 1'b0, addr, 64'h0123_4567_7654_3210);
			issue(1'b0, size, 1'b1, addr, '0);
			issue(1'b0, size, 1'b0, addr, '0);
		end

		// narrow stores keep the neighbouring lanes.
		issue(1'b1, size_double, 1'b0, 13'h200, 64'h1122_3344_5566_7788);
		issue(1'b1, size_byte, 1'b0, 13'h203, 64'h0000_0000_0000_00ab);
		issue(1'b1, size_half, 1'b0, 13'h206, 64'h0000_0000_0000_cdef);
		issue(1'b0, size_double, 1'b0, 13'h200, '0);

		// misaligned accesses, then memory unchanged.
		issue(1'b1, size_half, 1'b0, 13'h201, 64'hffff_ffff_ffff_ffff);
		issue(1'b1, size_word, 1'b0, 13'h202, 64'hffff_ffff_ffff_ffff);
		issue(1'b1, size_double, 1'b0, 13'h204, 64'hffff_ffff_ffff_ffff);
		issue(1'b0, size_word, 1'b1, 13'h205, '0);
		issue(1'b0, size_double, 1'b0, 13'h200, '0);
		idle(3);

		// store then load on consecutive cycles.
		for (int i = 0; i < 8; i++) begin
			issue(1'b1, size_word, 1'b0, 13'h300, 64'h8000_0000 + i * 64'h1111);
			issue(1'b0, size_word, 1'b1, 13'h300, '0);
		end
		idle(4);

		for (int i = 0; i < 3000; i++) begin
			size = access_size_t'($urandom_range(0, 3));
			addr = byte_addr_t'($urandom_range(0, 255));
			if ($urandom_range(0, 3) != 0)
				addr = addr & ~byte_addr_t'((1 << size) - 1); // mostly aligned.
			issue($urandom_range(0, 1), size, $urandom_range(0, 1), addr,
				{$urandom, $urandom});
			if ($urandom_range(0, 7) == 0)
				idle($urandom_range(1, 3));
		end
		idle(1);

		drain(timed_out);
		if (timed_out) begin
			$display("timeout: %0d responses never arrived", exp_q.size());
			errors++;
		end
		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
